//--- dv/eval_checker.sv
`timescale 1ns/1ns

module eval_checker
   import eval_pkg::*;
(
   input logic   clk,
   input logic   reset,
   input logic   board_req,
   input board_t board,
   input logic   board_ack,
   input eval_t  eval,
   input logic   eval_req,
   input logic   eval_ack
);

   int    mismatches;
   int    failures;
   int    boards_in;
   int    results_out;
   int    cyc;                 // negedge count
   int    req_rise_cyc;
   int    req_fall_cyc;
   int    ack_rise_cyc;
   int    eval_ack_fall_cyc;
   eval_t expected_q [$];
   logic  prev_board_req;
   logic  prev_board_ack;
   logic  prev_eval_req;
   logic  prev_eval_ack;
   eval_t prev_eval;

   initial
   begin
      mismatches        = 0;
      failures          = 0;
      boards_in         = 0;
      results_out       = 0;
      cyc               = 0;
      req_rise_cyc      = 0;
      req_fall_cyc      = 0;
      ack_rise_cyc      = 0;
      eval_ack_fall_cyc = -100;   // no result taken yet
      prev_board_req    = 1'b0;
      prev_board_ack    = 1'b0;
      prev_eval_req     = 1'b0;
      prev_eval_ack     = 1'b0;
      prev_eval         = '0;
   end

   task automatic flag_error(input string what);
      $display("Error at %0t: %s", $time, what);
      failures++;
   endtask

   // Reference score: material plus pawn structure, tapered by phase
   function automatic eval_t expected_eval(input board_t b);
      logic [3:0] code;
      int         kind, side, left, right, here;
      int         occ, phase, mat_mg, mat_eg;
      int         pen_mg [2];
      int         pen_eg [2];
      int         pawns [16];    // color * 8 + file
      eval_t      mat16_mg, mat16_eg, pawn16_mg, pawn16_eg;
      longint     mg, eg, mix, scale;
      eval_t      result;
      occ    = 0;
      mat_mg = 0;
      mat_eg = 0;
      for (int i = 0; i < 16; i++)
         pawns[i] = 0;
      for (int s = 0; s < 2; s++)
      begin
         pen_mg[s] = 0;
         pen_eg[s] = 0;
      end
      for (int n = 0; n < 64; n++)
      begin
         code = b[n*4 +: 4];
         kind = (code[2:0] == 3'd7) ? 0 : code[2:0];
         side = code[3];
         if (kind != 0)
            occ++;
         if (kind == 1)
            pawns[side*8 + n % 8]++;
         mat_mg += side ? -PIECE_MG[kind] : PIECE_MG[kind];
         mat_eg += side ? -PIECE_EG[kind] : PIECE_EG[kind];
      end
      for (int s = 0; s < 2; s++)
         for (int f = 0; f < 8; f++)
         begin
            here  = pawns[s*8 + f];
            left  = (f > 0) ? pawns[s*8 + f - 1] : 0;
            right = (f < 7) ? pawns[s*8 + f + 1] : 0;
            if (here > 1)
            begin
               pen_mg[s] += (here - 1) * DOUBLED_MG;
               pen_eg[s] += (here - 1) * DOUBLED_EG;
            end
            if (left == 0 && right == 0)
            begin
               pen_mg[s] += here * ISOLATED_MG;
               pen_eg[s] += here * ISOLATED_EG;
            end
         end
      mat16_mg  = mat_mg;                  // Each term is a 16-bit score
      mat16_eg  = mat_eg;
      pawn16_mg = pen_mg[1] - pen_mg[0];
      pawn16_eg = pen_eg[1] - pen_eg[0];
      mg = mat16_mg;
      mg += pawn16_mg;
      eg = mat16_eg;
      eg += pawn16_eg;
      phase = (occ > PHASE_MAX) ? PHASE_MAX : occ;
      mix   = mg * phase + eg * (PHASE_MAX - phase);
      scale = 1;
      scale = scale << SCALE_SHIFT;
      result = (mix * RECIP_62) / scale;   // signed divide truncates toward zero
      return result;
   endfunction

   always @(negedge clk)
   begin : watch
      eval_t want;
      int    due;
      cyc++;
      if (!reset)
      begin
         if (board_req && !prev_board_req)
            req_rise_cyc = cyc;
         if (!board_req && prev_board_req)
            req_fall_cyc = cyc;
         if (!eval_ack && prev_eval_ack)
            eval_ack_fall_cyc = cyc;
         if (board_ack && !prev_board_ack)
         begin
            // Idle intake acks 1 cycle after the sample, busy one after slot_free
            due = (req_rise_cyc + 2 > eval_ack_fall_cyc + 4) ?
                  req_rise_cyc + 2 : eval_ack_fall_cyc + 4;
            if (!prev_board_req)
               flag_error("board_ack rose although board_req was low when sampled");
            else if (cyc != due)
               flag_error($sformatf("board_ack rose at cycle %0d, expected cycle %0d",
                                    cyc, due));
            if (expected_q.size() != 0 || eval_req || eval_ack)
               flag_error("board_ack rose before the previous result was taken");
            expected_q.push_back(expected_eval(board));
            boards_in++;
            ack_rise_cyc = cyc;
         end
         if (!board_ack && prev_board_ack && (prev_board_req || cyc != req_fall_cyc + 2))
            flag_error("board_ack did not fall one cycle after board_req was sampled low");
         if (eval_req && !prev_eval_req)
         begin
            results_out++;
            if (expected_q.size() == 0)
               flag_error("eval_req rose with no board outstanding");
            else
            begin
               want = expected_q.pop_front();
               if (eval !== want)
               begin
                  $display("mismatch at %0t: eval got %0d expected %0d", $time, eval, want);
                  mismatches++;
               end
            end
            if (cyc != ack_rise_cyc + 6)
               flag_error($sformatf("eval_req rose %0d cycles after board_ack, expected 6",
                                    cyc - ack_rise_cyc));
         end
         if (eval_req && prev_eval_req && eval !== prev_eval)
            flag_error("eval changed while eval_req was high");
         if (!eval_req && prev_eval_req && !prev_eval_ack)
            flag_error("eval_req fell before eval_ack rose");
      end
      prev_board_req = board_req;
      prev_board_ack = board_ack;
      prev_eval_req  = eval_req;
      prev_eval_ack  = eval_ack;
      prev_eval      = eval;
   end

   task automatic report(input int sent);
      if (boards_in != sent || results_out != boards_in)
         flag_error($sformatf("boards and results do not add up: %0d sent, %0d in, %0d out",
                              sent, boards_in, results_out));
      $display("eval_checker: %0d boards in, %0d results out, %0d mismatches, %0d other errors",
               boards_in, results_out, mismatches, failures);
   endtask

endmodule

//--- dv/eval_tb.sv
`timescale 1ns/1ns

module eval_tb
   import eval_pkg::*;
();

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 10;
   localparam int DRIVE_DELAY  = 5;
   localparam int PER_TEST     = 75;
   localparam int NUM_BOARDS   = 4 * PER_TEST;
   localparam int WATCHDOG_NS  = NUM_BOARDS * 30 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

   logic        clk;
   logic        reset;
   logic        board_req;
   board_t      board;
   logic        board_ack;
   eval_t       eval;
   logic        eval_req;
   logic        eval_ack;

   logic [31:0] rng;
   bit          slow_ack;        // consumer always waits the full 6 cycles
   int          boards_sent;
   int          results_taken;

   eval_top i_dut (
      .clk       (clk),
      .reset     (reset),
      .board_req (board_req),
      .board     (board),
      .board_ack (board_ack),
      .eval      (eval),
      .eval_req  (eval_req),
      .eval_ack  (eval_ack)
   );

   eval_checker i_checker (
      .clk       (clk),
      .reset     (reset),
      .board_req (board_req),
      .board     (board),
      .board_ack (board_ack),
      .eval      (eval),
      .eval_req  (eval_req),
      .eval_ack  (eval_ack)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Random value below range
   task automatic roll(input int unsigned range, output int unsigned value);
      rng   = xorshift(rng);
      value = rng % range;
   endtask

   task automatic make_board(input int unsigned empty_pct, input int unsigned pawn_pct,
                             output board_t b);
      int unsigned r;
      logic [2:0]  kind;
      for (int n = 0; n < SQUARES; n++)
      begin
         roll(100, r);
         if (r < empty_pct)
         begin
            roll(8, r);
            kind = (r == 0) ? 3'd7 : 3'd0;   // Code 7 also reads as empty
         end
         else
         begin
            roll(100, r);
            if (r < pawn_pct)
               kind = 3'd1;
            else
            begin
               roll(5, r);
               kind = 3'd2 + r[2:0];          // Knight to king
            end
         end
         roll(2, r);
         b[n*PIECE_WIDTH +: PIECE_WIDTH] = {r[0], kind};
      end
   endtask

   // Four-phase board handshake, density picked from a range
   task automatic send_board(input int unsigned empty_lo, input int unsigned empty_hi,
                             input int unsigned pawn_pct);
      int unsigned density;
      board_t      b;
      @(posedge clk);
      #(DRIVE_DELAY);
      roll(empty_hi - empty_lo + 1, density);
      make_board(empty_lo + density, pawn_pct, b);
      board     = b;
      board_req = 1'b1;
      do @(negedge clk); while (!board_ack);
      @(posedge clk);
      #(DRIVE_DELAY);
      board_req = 1'b0;
      do @(negedge clk); while (board_ack);
      boards_sent++;
   endtask

   initial
   begin : consumer
      int unsigned wait_cycles;
      wait (reset === 1'b0);
      forever
      begin
         do @(negedge clk); while (!eval_req);
         if (slow_ack)
            wait_cycles = 6;
         else
            roll(7, wait_cycles);
         repeat (wait_cycles) @(posedge clk);
         @(posedge clk);
         #(DRIVE_DELAY);
         eval_ack = 1'b1;
         results_taken++;
         do @(negedge clk); while (eval_req);
         @(posedge clk);
         #(DRIVE_DELAY);
         eval_ack = 1'b0;
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout after %0d ns with %0d of %0d boards sent and %0d results taken",
               WATCHDOG_NS, boards_sent, NUM_BOARDS, results_taken);
      $display("Simulation failed");
      $finish;
   end

   initial
   begin
      rng           = 32'h8e93;
      reset         = 1'b1;
      board_req     = 1'b0;
      board         = '0;
      eval_ack      = 1'b0;
      slow_ack      = 1'b0;
      boards_sent   = 0;
      results_taken = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      #(DRIVE_DELAY);
      reset = 1'b0;

      for (int i = 0; i < PER_TEST; i++)   // Material only, bare to full boards
         send_board(0, 100, 0);
      for (int i = 0; i < PER_TEST; i++)   // Pawn heavy, stacked and lone pawns
         send_board(30, 70, 60);
      // Full boards cap the phase, sparse ones lean to endgame
      for (int i = 0; i < PER_TEST; i++)
         if (i % 2 == 0)
            send_board(0, 1, 25);
         else
            send_board(80, 97, 25);
      slow_ack = 1'b1;
      for (int i = 0; i < PER_TEST; i++)
         send_board(0, 100, 30);

      wait (results_taken == NUM_BOARDS);
      do @(negedge clk); while (eval_req || eval_ack);
      repeat (4) @(negedge clk);
      i_checker.report(boards_sent);
      if (i_checker.mismatches == 0 && i_checker.failures == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- eval_top.f
verilog/eval_pkg.sv
verilog/board_intake.sv
verilog/material_eval.sv
verilog/pawn_eval.sv
verilog/phase_blend.sv
verilog/result_port.sv
verilog/eval_top.sv
dv/eval_checker.sv
dv/eval_tb.sv

//--- verilog/board_intake.sv
`timescale 1ns/1ns

module board_intake
   import eval_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       board_req,
   input  board_t     board,
   output logic       board_ack,
   input  logic       slot_free,
   output board_job_t job,
   output logic       job_start
);

   piece_state_t state;
   logic         board_req_r;   // registered request
   logic         free_seen;     // slot_free came early, during ACK
   count_t       occ_count;

   // Occupied squares of the incoming board
   always_comb
   begin
      occ_count = '0;
      for (int n = 0; n < SQUARES; n++)
         if (piece_kind(board[n*PIECE_WIDTH +: PIECE_WIDTH]) != T_EMPTY)
            occ_count = occ_count + count_t'(1);
   end

   // Board is held stable by the source while board_req is high
   always_ff @(posedge clk)
      if (state == S_IDLE && board_req_r)
      begin
         job.board    <= board;
         job.occupied <= occ_count;
      end

   always_ff @(posedge clk)
      if (reset)
      begin
         state       <= S_IDLE;
         board_req_r <= 1'b0;
         board_ack   <= 1'b0;
         job_start   <= 1'b0;
         free_seen   <= 1'b0;
      end
      else
      begin
         board_req_r <= board_req;
         job_start   <= 1'b0;
         case (state)
            S_IDLE:
               if (board_req_r)
               begin
                  board_ack <= 1'b1;
                  job_start <= 1'b1;
                  free_seen <= 1'b0;
                  state     <= S_ACK;
               end
            S_ACK:
            begin
               if (slot_free)
                  free_seen <= 1'b1;
               if (!board_req_r)
               begin
                  board_ack <= 1'b0;
                  state     <= (free_seen || slot_free) ? S_IDLE : S_BUSY;
               end
            end
            S_BUSY:
               if (slot_free)
                  state <= S_IDLE;   // result taken, ready for next board
            default:
               state <= S_IDLE;
         endcase
      end

   // Source must have been requesting when the ack goes up
   a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
      $rose(board_ack) |-> $past(board_req));

endmodule

//--- verilog/eval_pkg.sv
package eval_pkg;

   localparam int SQUARES     = 64;
   localparam int PIECE_WIDTH = 4;
   localparam int EVAL_WIDTH  = 16;
   localparam int COUNT_WIDTH = 7;
   localparam int BLEND_WIDTH = 40;

   // Low three bits of a square code
   localparam logic [2:0] T_EMPTY = 3'd0;
   localparam logic [2:0] T_PAWN  = 3'd1;
   localparam logic [2:0] T_NONE  = 3'd7;    // unused code, reads as empty

   localparam int PIECE_MG [0:6] = '{0, 100, 320, 330, 500, 950, 0};
   localparam int PIECE_EG [0:6] = '{0, 120, 300, 320, 550, 1000, 0};

   localparam int DOUBLED_MG  = 15;
   localparam int DOUBLED_EG  = 25;
   localparam int ISOLATED_MG = 10;
   localparam int ISOLATED_EG = 20;

   // Taper by phase, divide by 62 via reciprocal
   localparam int PHASE_MAX   = 62;
   localparam int RECIP_62    = 16912;   // floor(2^20 / 62)
   localparam int SCALE_SHIFT = 20;

   typedef logic [PIECE_WIDTH-1:0]         piece_t;   // [3] black, [2:0] type
   typedef logic [SQUARES*PIECE_WIDTH-1:0] board_t;
   typedef logic signed [EVAL_WIDTH-1:0]   eval_t;
   typedef logic [COUNT_WIDTH-1:0]         count_t;

   typedef struct packed {
      board_t board;
      count_t occupied;
   } board_job_t;

   typedef struct packed {
      eval_t mg;
      eval_t eg;
   } score_pair_t;

   typedef enum logic [1:0] {S_IDLE, S_ACK, S_BUSY} piece_state_t;
   typedef enum logic [1:0] {O_IDLE, O_REQ, O_WAIT_ACK_LOW} out_state_t;

   // Piece type with code 7 folded onto empty
   function automatic logic [2:0] piece_kind(input piece_t p);
      return (p[2:0] == T_NONE) ? T_EMPTY : p[2:0];
   endfunction

endpackage

//--- verilog/eval_top.sv
`timescale 1ns/1ns

module eval_top
   import eval_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   board_req,
   input  board_t board,
   output logic   board_ack,
   output eval_t  eval,
   output logic   eval_req,
   input  logic   eval_ack
);

   board_job_t  job;
   logic        job_start;
   score_pair_t material_score;
   logic        material_valid;
   score_pair_t pawn_score;
   eval_t       result;
   logic        result_valid;
   logic        slot_free;

   board_intake i_intake (
      .clk       (clk),
      .reset     (reset),
      .board_req (board_req),
      .board     (board),
      .board_ack (board_ack),
      .slot_free (slot_free),
      .job       (job),
      .job_start (job_start)
   );

   material_eval i_material (
      .clk         (clk),
      .reset       (reset),
      .job         (job),
      .job_start   (job_start),
      .score       (material_score),
      .score_valid (material_valid)
   );

   pawn_eval i_pawns (
      .clk       (clk),
      .reset     (reset),
      .job       (job),
      .job_start (job_start),
      .score     (pawn_score)
   );

   // Pawn term has the same latency, so material valid covers both
   phase_blend i_blend (
      .clk          (clk),
      .reset        (reset),
      .material     (material_score),
      .pawns        (pawn_score),
      .occupied     (job.occupied),
      .in_valid     (material_valid),
      .result       (result),
      .result_valid (result_valid)
   );

   result_port i_result (
      .clk          (clk),
      .reset        (reset),
      .result       (result),
      .result_valid (result_valid),
      .eval         (eval),
      .eval_req     (eval_req),
      .eval_ack     (eval_ack),
      .slot_free    (slot_free)
   );

endmodule

//--- verilog/material_eval.sv
`timescale 1ns/1ns

module material_eval
   import eval_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  board_job_t  job,
   input  logic        job_start,
   output score_pair_t score,
   output logic        score_valid
);

   int mg_acc;
   int eg_acc;

   // White adds, black subtracts
   always_comb
   begin : sum_pieces
      piece_t     p;
      logic [2:0] kind;
      mg_acc = 0;
      eg_acc = 0;
      for (int n = 0; n < SQUARES; n++)
      begin
         p    = job.board[n*PIECE_WIDTH +: PIECE_WIDTH];
         kind = piece_kind(p);
         if (p[3])
         begin
            mg_acc = mg_acc - PIECE_MG[kind];
            eg_acc = eg_acc - PIECE_EG[kind];
         end
         else
         begin
            mg_acc = mg_acc + PIECE_MG[kind];
            eg_acc = eg_acc + PIECE_EG[kind];
         end
      end
   end

   always_ff @(posedge clk)
      if (job_start)
      begin
         score.mg <= eval_t'(mg_acc);
         score.eg <= eval_t'(eg_acc);
      end

   always_ff @(posedge clk)
      if (reset)
         score_valid <= 1'b0;
      else
         score_valid <= job_start;   // same cycle as the pawn term

endmodule

//--- verilog/pawn_eval.sv
`timescale 1ns/1ns

module pawn_eval
   import eval_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  board_job_t  job,
   input  logic        job_start,
   output score_pair_t score
);

   logic [7:0][3:0] w_cnt;   // pawns per file, a to h
   logic [7:0][3:0] b_cnt;
   score_pair_t     w_pen;
   score_pair_t     b_pen;

   // Doubled and isolated penalties of one color
   function automatic score_pair_t file_penalty(input logic [7:0][3:0] cnt);
      score_pair_t     pen;
      logic [9:0][3:0] padded;   // empty file on each edge
      pen    = '0;
      padded = {4'd0, cnt, 4'd0};
      for (int f = 0; f < 8; f++)
      begin
         if (cnt[f] > 4'd1)
         begin
            pen.mg += eval_t'((cnt[f] - 4'd1) * DOUBLED_MG);
            pen.eg += eval_t'((cnt[f] - 4'd1) * DOUBLED_EG);
         end
         // padded[f] is file f-1, padded[f+2] is file f+1
         if (padded[f] == 4'd0 && padded[f+2] == 4'd0)
         begin
            pen.mg += eval_t'(cnt[f] * ISOLATED_MG);
            pen.eg += eval_t'(cnt[f] * ISOLATED_EG);
         end
      end
      return pen;
   endfunction

   always_comb
   begin : count_files
      piece_t p;
      w_cnt = '0;
      b_cnt = '0;
      for (int n = 0; n < SQUARES; n++)
      begin
         p = job.board[n*PIECE_WIDTH +: PIECE_WIDTH];
         if (piece_kind(p) == T_PAWN)
         begin
            if (p[3])
               b_cnt[n % 8] = b_cnt[n % 8] + 4'd1;
            else
               w_cnt[n % 8] = w_cnt[n % 8] + 4'd1;
         end
      end
   end

   assign w_pen = file_penalty(w_cnt);
   assign b_pen = file_penalty(b_cnt);

   // Penalties hurt their own side
   always_ff @(posedge clk)
      if (reset)
         score <= '0;
      else if (job_start)
      begin
         score.mg <= b_pen.mg - w_pen.mg;
         score.eg <= b_pen.eg - w_pen.eg;
      end

endmodule

//--- verilog/phase_blend.sv
`timescale 1ns/1ns

module phase_blend
   import eval_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  score_pair_t material,
   input  score_pair_t pawns,
   input  count_t      occupied,
   input  logic        in_valid,
   output eval_t       result,
   output logic        result_valid
);

   logic signed [BLEND_WIDTH-1:0] mg_s1, eg_s1;
   count_t                        phase_s1;
   count_t                        eg_weight;
   logic signed [BLEND_WIDTH-1:0] mg_prod, eg_prod;
   logic signed [BLEND_WIDTH-1:0] mix;
   logic signed [BLEND_WIDTH-1:0] scaled;
   logic signed [BLEND_WIDTH-1:0] bias;
   logic signed [BLEND_WIDTH-1:0] biased;
   logic [3:0]                    vld;   // one bit per stage

   assign eg_weight = count_t'(PHASE_MAX) - phase_s1;

   // Reciprocal multiply, then round toward zero before the shift
   assign scaled = mix * RECIP_62;
   assign bias   = scaled[BLEND_WIDTH-1] ?
                   (BLEND_WIDTH'(1) << SCALE_SHIFT) - BLEND_WIDTH'(1) : '0;
   assign biased = scaled + bias;

   always_ff @(posedge clk)
   begin
      mg_s1    <= $signed(material.mg) + $signed(pawns.mg);
      eg_s1    <= $signed(material.eg) + $signed(pawns.eg);
      phase_s1 <= (occupied > PHASE_MAX) ? count_t'(PHASE_MAX) : occupied;
      mg_prod  <= mg_s1 * $signed({1'b0, phase_s1});
      eg_prod  <= eg_s1 * $signed({1'b0, eg_weight});
      mix      <= mg_prod + eg_prod;
      result   <= eval_t'(biased >>> SCALE_SHIFT);
   end

   always_ff @(posedge clk)
      if (reset)
         vld <= '0;
      else
         vld <= {vld[2:0], in_valid};

   assign result_valid = vld[3];

   // Intake holds the job while the term evaluators finish
   a_occ_held: assert property (@(posedge clk) disable iff (reset)
      in_valid |-> $stable(occupied));

endmodule

//--- verilog/result_port.sv
`timescale 1ns/1ns

module result_port
   import eval_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  eval_t result,
   input  logic  result_valid,
   output eval_t eval,
   output logic  eval_req,
   input  logic  eval_ack,
   output logic  slot_free
);

   out_state_t state;
   logic       eval_ack_r;   // registered consumer ack

   always_ff @(posedge clk)
      if (state == O_IDLE && result_valid)
         eval <= result;

   always_ff @(posedge clk)
      if (reset)
      begin
         state      <= O_IDLE;
         eval_ack_r <= 1'b0;
         eval_req   <= 1'b0;
         slot_free  <= 1'b0;
      end
      else
      begin
         eval_ack_r <= eval_ack;
         slot_free  <= 1'b0;
         case (state)
            O_IDLE:
               if (result_valid)
               begin
                  eval_req <= 1'b1;
                  state    <= O_REQ;
               end
            O_REQ:
               if (eval_ack_r)
               begin
                  eval_req <= 1'b0;
                  state    <= O_WAIT_ACK_LOW;
               end
            O_WAIT_ACK_LOW:
               if (!eval_ack_r)
               begin
                  slot_free <= 1'b1;   // lets intake take the next board
                  state     <= O_IDLE;
               end
            default:
               state <= O_IDLE;
         endcase
      end

   a_eval_stable: assert property (@(posedge clk) disable iff (reset)
      eval_req |=> $stable(eval));

   a_req_held: assert property (@(posedge clk) disable iff (reset)
      eval_req && !eval_ack |=> eval_req);

endmodule
